//--- filelist.f
src/mipsIsaPkg.sv
src/ctrlPkg.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/writebackStage.sv
src/controlUnit.sv
bench/controlUnit_assert.sv
bench/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module controlUnitTb -f filelist.f -o controlUnitSim

# the simulator exits non-zero on failure; the log decides the result
./obj_dir/controlUnitSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- bench/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb;

	import mipsIsaPkg::*;
	import ctrlPkg::*;

	localparam int EdgeLimit = 60;

	logic clk;
	logic rstN;
	opcodeE opD;
	logic [4:0] rtD;
	functE functD;
	logic branchTakenD, stallE, flushE;
	logic pcSrcD, branchD, jumpD, jalD, jrD;
	logic aluSrcE, regDstE, balE, jalE, jrE, mulOrDivE, isSignE;
	logic [4:0] aluOpOutE;
	logic memWriteE, hiloWriteE, regToHiloHiE, regToHiloLoE, mdToHiloE, hiloSrcE;
	logic memToRegE, regWriteE, hiloToRegE;
	logic memWriteM, hiloWriteM, regToHiloHiM, regToHiloLoM, mdToHiloM, hiloSrcM;
	logic memToRegM, regWriteM, hiloToRegM;
	logic memToRegW, regWriteW, hiloToRegW;

	// observed words in the ctrlPkg field order
	logic [20:0] actE;
	logic [8:0]  actM;
	logic [2:0]  actW;
	logic [4:0]  actDec;

	// stimulus table
	string       rowName[$];
	logic [5:0]  rowOp[$];
	logic [4:0]  rowRt[$];
	logic [5:0]  rowFn[$];
	logic [20:0] rowWord[$];
	logic [1:0]  rowBrJmp[$];

	// pipeline reference model
	logic [20:0] expE = '0;
	logic [8:0]  expM = '0;
	logic [2:0]  expW = '0;
	string       nameE = "reset";
	string       nameM = "reset";
	string       nameW = "reset";

	logic [31:0] randState = 32'he325;
	bit          taken;
	int          stallCount = 0;
	int          flushCount = 0;
	int          flushStallCount = 0;

	controlUnit dut (.*, .aluOpE(aluOpOutE));

	assign actE = {aluSrcE, regDstE, aluOpOutE, balE, jalE, jrE, mulOrDivE, isSignE,
		memWriteE, hiloWriteE, regToHiloHiE, regToHiloLoE, mdToHiloE, hiloSrcE,
		memToRegE, regWriteE, hiloToRegE};
	assign actM = {memWriteM, hiloWriteM, regToHiloHiM, regToHiloLoM, mdToHiloM, hiloSrcM,
		memToRegM, regWriteM, hiloToRegM};
	assign actW = {memToRegW, regWriteW, hiloToRegW};
	assign actDec = {pcSrcD, branchD, jumpD, jalD, jrD};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// polls sit half a ns off the clock toggles, lands 2 ns after the edge
	task automatic nextEdge();
		int polls;
		polls = 0;
		#0.5;
		while (clk === 1'b1 && polls < EdgeLimit) begin
			#1;
			polls++;
		end
		while (clk === 1'b0 && polls < EdgeLimit) begin
			#1;
			polls++;
		end
		if (polls >= EdgeLimit) begin
			$display("timeout: no rising clock edge seen within %0d ns", EdgeLimit);
			$display("RESULT: FAIL");
			$fatal(1, "clock stopped");
		end
		#1.5;
	endtask

	// ex is {aluSrc, regDst, bal, jal, jr, mulOrDiv, isSign}
	task automatic addRow(input string name, input logic [5:0] op, input logic [4:0] rt,
			input logic [5:0] fn, input logic [4:0] aluOp, input logic [6:0] ex,
			input logic [5:0] mem, input logic [2:0] wb, input logic [1:0] brJmp);
		rowName.push_back(name);
		rowOp.push_back(op);
		rowRt.push_back(rt);
		rowFn.push_back(fn);
		rowWord.push_back({ex[6:5], aluOp, ex[4:0], mem, wb});
		rowBrJmp.push_back(brJmp);
	endtask

	task automatic checkPipeline();
		checkValue({nameE, " E"}, 32'(expE), 32'(actE));
		checkValue({nameM, " M"}, 32'(expM), 32'(actM));
		checkValue({nameW, " W"}, 32'(expW), 32'(actW));
	endtask

	// one clock with row i at decode
	task automatic runCycle(input int i, input bit stall, input bit flush);
		checkPipeline();
		opD          = opcodeE'(rowOp[i]);
		rtD          = rowRt[i];
		functD       = functE'(rowFn[i]);
		branchTakenD = taken;
		stallE       = stall;
		flushE       = flush;
		#1;
		checkValue({rowName[i], " decode"},
			32'({rowBrJmp[i][1] & taken, rowBrJmp[i], rowWord[i][12], rowWord[i][11]}),
			32'(actDec));
		nextEdge();
		expW  = expM[2:0];
		nameW = nameM;
		expM  = expE[8:0];
		nameM = nameE;
		if (flush) begin
			expE  = '0;
			nameE = "flush";
		end else if (!stall) begin
			expE  = rowWord[i];
			nameE = rowName[i];
		end
	endtask

	// ====================
	// instruction table
	// ====================
	task automatic loadTable();
		// name, op, rt, funct, aluOp, ex, {memWrite, hiloWrite, regToHiloHi,
		// regToHiloLo, mdToHilo, hiloSrc}, {memToReg, regWrite, hiloToReg}, {branch, jump}
		addRow("add", opSpecial, 5'd0, fnAdd, aluAdd, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("addu", opSpecial, 5'd0, fnAddu, aluAddu, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("sub", opSpecial, 5'd0, fnSub, aluSub, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("subu", opSpecial, 5'd0, fnSubu, aluSubu, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("and", opSpecial, 5'd0, fnAnd, aluAnd, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("or", opSpecial, 5'd0, fnOr, aluOr, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("xor", opSpecial, 5'd0, fnXor, aluXor, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("nor", opSpecial, 5'd0, fnNor, aluNor, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("slt", opSpecial, 5'd0, fnSlt, aluSlt, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("sltu", opSpecial, 5'd0, fnSltu, aluSltu, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("sll", opSpecial, 5'd0, fnSll, aluSll, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("srl", opSpecial, 5'd0, fnSrl, aluSrl, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("sra", opSpecial, 5'd0, fnSra, aluSra, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("sllv", opSpecial, 5'd0, fnSllv, aluSll, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("srlv", opSpecial, 5'd0, fnSrlv, aluSrl, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("srav", opSpecial, 5'd0, fnSrav, aluSra, 7'b0100000, 6'b000000, 3'b010, 2'b00);
		addRow("jr", opSpecial, 5'd0, fnJr, aluNop, 7'b0100100, 6'b000000, 3'b000, 2'b01);
		addRow("mult", opSpecial, 5'd0, fnMult, aluNop, 7'b0100001, 6'b010010, 3'b000, 2'b00);
		addRow("multu", opSpecial, 5'd0, fnMultu, aluNop, 7'b0100000, 6'b010010, 3'b000, 2'b00);
		addRow("div", opSpecial, 5'd0, fnDiv, aluNop, 7'b0100011, 6'b010010, 3'b000, 2'b00);
		addRow("divu", opSpecial, 5'd0, fnDivu, aluNop, 7'b0100010, 6'b010010, 3'b000, 2'b00);
		addRow("mfhi", opSpecial, 5'd0, fnMfhi, aluNop, 7'b0100000, 6'b000001, 3'b011, 2'b00);
		addRow("mflo", opSpecial, 5'd0, fnMflo, aluNop, 7'b0100000, 6'b000000, 3'b011, 2'b00);
		addRow("mthi", opSpecial, 5'd0, fnMthi, aluNop, 7'b0100000, 6'b011001, 3'b000, 2'b00);
		addRow("mtlo", opSpecial, 5'd0, fnMtlo, aluNop, 7'b0100000, 6'b010100, 3'b000, 2'b00);
		addRow("addi", opAddi, 5'd0, 6'h00, aluAdd, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("addiu", opAddiu, 5'd0, 6'h00, aluAddu, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("andi", opAndi, 5'd0, 6'h00, aluAnd, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("ori", opOri, 5'd0, 6'h00, aluOr, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("xori", opXori, 5'd0, 6'h00, aluXor, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("lui", opLui, 5'd0, 6'h00, aluLui, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("slti", opSlti, 5'd0, 6'h00, aluSlt, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("sltiu", opSltiu, 5'd0, 6'h00, aluSltu, 7'b1000000, 6'b000000, 3'b010, 2'b00);
		addRow("lw", opLw, 5'd0, 6'h00, aluAddu, 7'b1000000, 6'b000000, 3'b110, 2'b00);
		addRow("sw", opSw, 5'd0, 6'h00, aluAddu, 7'b1000000, 6'b100000, 3'b000, 2'b00);
		addRow("beq", opBeq, 5'd0, 6'h00, aluSub, 7'b0000000, 6'b000000, 3'b000, 2'b10);
		addRow("bne", opBne, 5'd0, 6'h00, aluSub, 7'b0000000, 6'b000000, 3'b000, 2'b10);
		addRow("bltz", opRegimm, rtBltz, 6'h00, aluNop, 7'b0000000, 6'b000000, 3'b000, 2'b10);
		addRow("bgez", opRegimm, rtBgez, 6'h00, aluNop, 7'b0000000, 6'b000000, 3'b000, 2'b10);
		addRow("bltzal", opRegimm, rtBltzal, 6'h00, aluNop, 7'b0010000, 6'b000000, 3'b010, 2'b10);
		addRow("bgezal", opRegimm, rtBgezal, 6'h00, aluNop, 7'b0010000, 6'b000000, 3'b010, 2'b10);
		addRow("j", opJ, 5'd0, 6'h00, aluNop, 7'b0000000, 6'b000000, 3'b000, 2'b01);
		addRow("jal", opJal, 5'd0, 6'h00, aluNop, 7'b0001000, 6'b000000, 3'b010, 2'b01);
		// encodings outside the subset
		addRow("bad op", 6'h3f, 5'd0, 6'h00, aluNop, 7'b0000000, 6'b000000, 3'b000, 2'b00);
		addRow("bad funct", opSpecial, 5'd0, 6'h01, aluNop, 7'b0000000, 6'b000000, 3'b000, 2'b00);
		addRow("bad rt", opRegimm, 5'h05, 6'h00, aluNop, 7'b0000000, 6'b000000, 3'b000, 2'b00);
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int stallCycles;
		int flushKind;
		rstN         = 1'b0;
		opD          = opSpecial;
		rtD          = '0;
		functD       = fnSll;
		branchTakenD = 1'b0;
		stallE       = 1'b0;
		flushE       = 1'b0;
		loadTable();
		nextEdge();
		nextEdge();
		rstN = 1'b1;

		for (int i = 0; i < rowName.size(); i++) begin
			randState   = lcgNext(randState);
			taken       = randState[16];
			stallCycles = (randState[19:18] == 2'd0) ? 1 + int'(randState[21:20]) : 0;
			flushKind   = int'(randState[25:24]);
			// kind 1 flushes alone, kind 2 flushes with stall also high
			if (flushKind == 1 || flushKind == 2) begin
				runCycle(i, flushKind == 2, 1'b1);
				flushCount++;
				if (flushKind == 2)
					flushStallCount++;
			end
			for (int s = 0; s < stallCycles; s++)
				runCycle(i, 1'b1, 1'b0);
			if (stallCycles > 0)
				stallCount++;
			runCycle(i, 1'b0, 1'b0);
		end

		// drain the last rows into writeback
		for (int d = 0; d < 3; d++)
			runCycle(rowName.size() - 1, 1'b0, 1'b0);
		checkPipeline();

		if (stallCount == 0 || flushCount == 0 || flushStallCount == 0) begin
			$display("a stall, flush or combined flush and stall sequence never ran");
			$display("RESULT: FAIL");
			$fatal(1, "sequence not exercised");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

//--- bench/controlUnit_assert.sv
`timescale 1ns/10ps

module controlUnitAssert (
	input logic             clk,
	input logic             rstN,
	input logic             stallE,
	input logic             flushE,
	input logic             branchD,
	input logic             jumpD,
	input ctrlPkg::exCtrlT  exE,
	input ctrlPkg::memCtrlT memE,
	input ctrlPkg::wbCtrlT  wbE,
	input ctrlPkg::memCtrlT memM,
	input ctrlPkg::wbCtrlT  wbM
);

	// branch and jump decode are exclusive
	assert property (@(posedge clk) disable iff (!rstN) branchD |-> !jumpD)
		else $error("branchD and jumpD high together");

	// flush inserts a bubble
	assert property (@(posedge clk) disable iff (!rstN)
		flushE |=> (exE == '0 && memE == '0 && wbE == '0))
		else $error("E register not cleared by flush");

	assert property (@(posedge clk) disable iff (!rstN)
		(stallE && !flushE) |=>
			(exE == $past(exE) && memE == $past(memE) && wbE == $past(wbE)))
		else $error("E register changed during stall");

	// M always follows E by one clock
	assert property (@(posedge clk) disable iff (!rstN)
		1'b1 |=> (memM == $past(memE) && wbM == $past(wbE)))
		else $error("M register does not follow E");

endmodule

bind controlUnit controlUnitAssert uAssert (.*);

//--- src/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input  logic               clk,
	input  logic               rstN,
	// decode
	input  mipsIsaPkg::opcodeE opD,
	input  logic [4:0]         rtD,
	input  mipsIsaPkg::functE  functD,
	input  logic               branchTakenD,
	output logic               pcSrcD,
	output logic               branchD,
	output logic               jumpD,
	output logic               jalD,
	output logic               jrD,
	// execute
	input  logic               stallE,
	input  logic               flushE,
	output logic               aluSrcE,
	output logic               regDstE,
	output ctrlPkg::aluOpE     aluOpE,
	output logic               balE,
	output logic               jalE,
	output logic               jrE,
	output logic               mulOrDivE,
	output logic               isSignE,
	output logic               memWriteE,
	output logic               hiloWriteE,
	output logic               regToHiloHiE,
	output logic               regToHiloLoE,
	output logic               mdToHiloE,
	output logic               hiloSrcE,
	output logic               memToRegE,
	output logic               regWriteE,
	output logic               hiloToRegE,
	// memory
	output logic               memWriteM,
	output logic               hiloWriteM,
	output logic               regToHiloHiM,
	output logic               regToHiloLoM,
	output logic               mdToHiloM,
	output logic               hiloSrcM,
	output logic               memToRegM,
	output logic               regWriteM,
	output logic               hiloToRegM,
	// writeback
	output logic               memToRegW,
	output logic               regWriteW,
	output logic               hiloToRegW
);

	import ctrlPkg::*;

	exCtrlT  exD, exE;
	memCtrlT memD, memE, memM;
	wbCtrlT  wbD, wbE, wbM, wbW;

	// ====================
	// stage chain
	// ====================
	decodeStage uDecode (
		.opD          (opD),
		.rtD          (rtD),
		.functD       (functD),
		.branchTakenD (branchTakenD),
		.pcSrcD       (pcSrcD),
		.branchD      (branchD),
		.jumpD        (jumpD),
		.jalD         (jalD),
		.jrD          (jrD),
		.exD          (exD),
		.memD         (memD),
		.wbD          (wbD)
	);

	executeStage uExecute (
		.clk    (clk),
		.rstN   (rstN),
		.stallE (stallE),
		.flushE (flushE),
		.exD    (exD),
		.memD   (memD),
		.wbD    (wbD),
		.exE    (exE),
		.memE   (memE),
		.wbE    (wbE)
	);

	memoryStage uMemory (
		.clk  (clk),
		.rstN (rstN),
		.memE (memE),
		.wbE  (wbE),
		.memM (memM),
		.wbM  (wbM)
	);

	writebackStage uWriteback (
		.clk  (clk),
		.rstN (rstN),
		.wbM  (wbM),
		.wbW  (wbW)
	);

	// ====================
	// flatten to ports
	// ====================
	assign aluSrcE      = exE.aluSrc;
	assign regDstE      = exE.regDst;
	assign aluOpE       = exE.aluOp;
	assign balE         = exE.bal;
	assign jalE         = exE.jal;
	assign jrE          = exE.jr;
	assign mulOrDivE    = exE.mulOrDiv;
	assign isSignE      = exE.isSign;
	assign memWriteE    = memE.memWrite;
	assign hiloWriteE   = memE.hiloWrite;
	assign regToHiloHiE = memE.regToHiloHi;
	assign regToHiloLoE = memE.regToHiloLo;
	assign mdToHiloE    = memE.mdToHilo;
	assign hiloSrcE     = memE.hiloSrc;
	assign memToRegE    = wbE.memToReg;
	assign regWriteE    = wbE.regWrite;
	assign hiloToRegE   = wbE.hiloToReg;

	assign memWriteM    = memM.memWrite;
	assign hiloWriteM   = memM.hiloWrite;
	assign regToHiloHiM = memM.regToHiloHi;
	assign regToHiloLoM = memM.regToHiloLo;
	assign mdToHiloM    = memM.mdToHilo;
	assign hiloSrcM     = memM.hiloSrc;
	assign memToRegM    = wbM.memToReg;
	assign regWriteM    = wbM.regWrite;
	assign hiloToRegM   = wbM.hiloToReg;

	assign memToRegW    = wbW.memToReg;
	assign regWriteW    = wbW.regWrite;
	assign hiloToRegW   = wbW.hiloToReg;

endmodule

//--- src/writebackStage.sv
`timescale 1ns/10ps

module writebackStage (
	input  logic            clk,
	input  logic            rstN,
	input  ctrlPkg::wbCtrlT wbM,
	output ctrlPkg::wbCtrlT wbW
);

	// memory -> writeback
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbW <= '0;
		end else begin
			wbW <= wbM;
		end
	end

endmodule

//--- src/memoryStage.sv
`timescale 1ns/10ps

module memoryStage (
	input  logic             clk,
	input  logic             rstN,
	input  ctrlPkg::memCtrlT memE,
	input  ctrlPkg::wbCtrlT  wbE,
	output ctrlPkg::memCtrlT memM,
	output ctrlPkg::wbCtrlT  wbM
);

	// execute -> memory, advances every clock
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memM <= '0;
			wbM  <= '0;
		end else begin
			memM <= memE;
			wbM  <= wbE;
		end
	end

endmodule

//--- src/executeStage.sv
`timescale 1ns/10ps

module executeStage (
	input  logic             clk,
	input  logic             rstN,
	input  logic             stallE,
	input  logic             flushE,
	input  ctrlPkg::exCtrlT  exD,
	input  ctrlPkg::memCtrlT memD,
	input  ctrlPkg::wbCtrlT  wbD,
	output ctrlPkg::exCtrlT  exE,
	output ctrlPkg::memCtrlT memE,
	output ctrlPkg::wbCtrlT  wbE
);

	// decode -> execute register, 21 bits
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exE  <= '0;
			memE <= '0;
			wbE  <= '0;
		end else if (flushE) begin
			// bubble, wins over stall
			exE  <= '0;
			memE <= '0;
			wbE  <= '0;
		end else if (!stallE) begin
			exE  <= exD;
			memE <= memD;
			wbE  <= wbD;
		end
	end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
	input  mipsIsaPkg::opcodeE opD,
	input  logic [4:0]         rtD,
	input  mipsIsaPkg::functE  functD,
	input  logic               branchTakenD,
	output logic               pcSrcD,
	output logic               branchD,
	output logic               jumpD,
	output logic               jalD,
	output logic               jrD,
	output ctrlPkg::exCtrlT    exD,
	output ctrlPkg::memCtrlT   memD,
	output ctrlPkg::wbCtrlT    wbD
);

	import mipsIsaPkg::*;
	import ctrlPkg::*;

	aluOpE aluOpD;

	// ====================
	// alu decoder
	// ====================
	always_comb begin
		aluOpD = aluNop;
		case (opD)
			opSpecial: begin
				case (functD)
					fnAdd:          aluOpD = aluAdd;
					fnAddu:         aluOpD = aluAddu;
					fnSub:          aluOpD = aluSub;
					fnSubu:         aluOpD = aluSubu;
					fnAnd:          aluOpD = aluAnd;
					fnOr:           aluOpD = aluOr;
					fnXor:          aluOpD = aluXor;
					fnNor:          aluOpD = aluNor;
					fnSlt:          aluOpD = aluSlt;
					fnSltu:         aluOpD = aluSltu;
					fnSll, fnSllv:  aluOpD = aluSll;
					fnSrl, fnSrlv:  aluOpD = aluSrl;
					fnSra, fnSrav:  aluOpD = aluSra;
					default:        aluOpD = aluNop;
				endcase
			end
			opAddi:                aluOpD = aluAdd;
			opAddiu, opLw, opSw:   aluOpD = aluAddu;
			// compare for equality by subtraction
			opBeq, opBne:          aluOpD = aluSub;
			opSlti:                aluOpD = aluSlt;
			opSltiu:               aluOpD = aluSltu;
			opAndi:                aluOpD = aluAnd;
			opOri:                 aluOpD = aluOr;
			opXori:                aluOpD = aluXor;
			opLui:                 aluOpD = aluLui;
			default:               aluOpD = aluNop;
		endcase
	end

	// ====================
	// main decoder
	// ====================
	always_comb begin
		exD     = '0;
		memD    = '0;
		wbD     = '0;
		branchD = 1'b0;
		jumpD   = 1'b0;
		case (opD)
			opSpecial: begin
				case (functD)
					fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
					fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
						wbD.regWrite = 1'b1;
					end
					fnJr: begin
						exD.jr = 1'b1;
						jumpD  = 1'b1;
					end
					fnMult, fnMultu, fnDiv, fnDivu: begin
						memD.hiloWrite = 1'b1;
						memD.mdToHilo  = 1'b1;
						exD.mulOrDiv   = (functD == fnDiv) || (functD == fnDivu);
						exD.isSign     = (functD == fnMult) || (functD == fnDiv);
					end
					fnMfhi, fnMflo: begin
						wbD.regWrite  = 1'b1;
						wbD.hiloToReg = 1'b1;
						memD.hiloSrc  = (functD == fnMfhi);
					end
					fnMthi: begin
						memD.hiloWrite   = 1'b1;
						memD.regToHiloHi = 1'b1;
						memD.hiloSrc     = 1'b1;
					end
					fnMtlo: begin
						memD.hiloWrite   = 1'b1;
						memD.regToHiloLo = 1'b1;
					end
					default: begin
					end
				endcase
				// every known funct set at least one of these
				exD.regDst = wbD.regWrite | memD.hiloWrite | exD.jr;
			end
			opRegimm: begin
				case (rtD)
					rtBltz, rtBgez: begin
						branchD = 1'b1;
					end
					rtBltzal, rtBgezal: begin
						branchD      = 1'b1;
						exD.bal      = 1'b1;
						wbD.regWrite = 1'b1;
					end
					default: begin
					end
				endcase
			end
			opJ: begin
				jumpD = 1'b1;
			end
			opJal: begin
				jumpD        = 1'b1;
				exD.jal      = 1'b1;
				wbD.regWrite = 1'b1;
			end
			opBeq, opBne: begin
				branchD = 1'b1;
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				wbD.regWrite = 1'b1;
				exD.aluSrc   = 1'b1;
			end
			opLw: begin
				wbD.regWrite = 1'b1;
				wbD.memToReg = 1'b1;
				exD.aluSrc   = 1'b1;
			end
			opSw: begin
				memD.memWrite = 1'b1;
				exD.aluSrc    = 1'b1;
			end
			default: begin
			end
		endcase
		exD.aluOp = aluOpD;
	end

	// branch condition comes from the datapath comparator
	assign pcSrcD = branchD & branchTakenD;
	assign jalD   = exD.jal;
	assign jrD    = exD.jr;

endmodule

//--- src/ctrlPkg.sv
package ctrlPkg;

	// zero encoding is aluAdd, the value after reset or flush
	typedef enum logic [4:0] {
		aluAdd,
		aluAddu,
		aluSub,
		aluSubu,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui,
		aluNop
	} aluOpE;

	// consumed in execute only
	typedef struct packed {
		logic  aluSrc;
		logic  regDst;
		aluOpE aluOp;
		logic  bal;
		logic  jal;
		logic  jr;
		logic  mulOrDiv;  // 1 = divide
		logic  isSign;
	} exCtrlT;

	// carried through memory
	typedef struct packed {
		logic memWrite;
		logic hiloWrite;
		logic regToHiloHi;
		logic regToHiloLo;
		logic mdToHilo;
		logic hiloSrc;    // 1 = hi
	} memCtrlT;

	// carried through writeback
	typedef struct packed {
		logic memToReg;
		logic regWrite;
		logic hiloToReg;
	} wbCtrlT;

endpackage

//--- src/mipsIsaPkg.sv
package mipsIsaPkg;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opRegimm  = 6'h01,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opSltiu   = 6'h0b,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opXori    = 6'h0e,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// funct field of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		fnSll   = 6'h00,
		fnSrl   = 6'h02,
		fnSra   = 6'h03,
		fnSllv  = 6'h04,
		fnSrlv  = 6'h06,
		fnSrav  = 6'h07,
		fnJr    = 6'h08,
		fnMfhi  = 6'h10,
		fnMthi  = 6'h11,
		fnMflo  = 6'h12,
		fnMtlo  = 6'h13,
		fnMult  = 6'h18,
		fnMultu = 6'h19,
		fnDiv   = 6'h1a,
		fnDivu  = 6'h1b,
		fnAdd   = 6'h20,
		fnAddu  = 6'h21,
		fnSub   = 6'h22,
		fnSubu  = 6'h23,
		fnAnd   = 6'h24,
		fnOr    = 6'h25,
		fnXor   = 6'h26,
		fnNor   = 6'h27,
		fnSlt   = 6'h2a,
		fnSltu  = 6'h2b
	} functE;

	// rt field of REGIMM
	typedef enum logic [4:0] {
		rtBltz   = 5'h00,
		rtBgez   = 5'h01,
		rtBltzal = 5'h10,
		rtBgezal = 5'h11
	} regimmE;

endpackage
